// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := ram_controller_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/access_timer.sv ====
/* Access timer: counts out the back-end command accept and data return
   delay of a main-memory access */

`default_nettype none

module access_timer
(
   input  wire  clk,
   input  wire  reset,
   input  wire  start,
   output logic done
);
   import ram_ctrl_pkg::*;

   logic [TIMER_W-1:0] count;

   always_ff @(posedge clk)
   begin
      if (reset)
         count <= '0;
      else if (start)
         count <= TIMER_W'(MEM_LATENCY);
      else if (count != '0)
         count <= count - 1'b1;
   end

   // Last count cycle or idle at zero
   assign done = !start && (count <= TIMER_W'(1));

endmodule

`default_nettype wire

// ==== hw/main_mem_array.sv ====
/* Main memory array: on-chip word store standing in for SDRAM, with
   all-ones reads and ignored writes above the implemented range */

`default_nettype none

module main_mem_array
(
   input  wire                          clk,
   input  wire ram_addr_pkg::sdram_addr_t addr,
   input  wire ram_addr_pkg::word_t     wdata,
   input  wire                          write_en,
   output ram_addr_pkg::word_t          rdata
);
   import ram_addr_pkg::*;

   word_t              mem [MAIN_WORDS];
   logic [MAIN_AW-1:0] index;
   logic               in_range;

   initial
   begin
      for (int i = 0; i < MAIN_WORDS; i++)
         mem[i] = '0;
   end

   // High address bits must be clear
   assign in_range = (addr[SDRAM_AW-1:MAIN_AW] == '0);
   assign index    = addr[MAIN_AW-1:0];

   always_ff @(posedge clk)
   begin
      if (write_en && in_range)
         mem[index] <= wdata;
   end

   assign rdata = in_range ? mem[index] : BAD_WORD;

endmodule

`default_nettype wire

// ==== hw/ram_addr_pkg.sv ====
/* Memory address package: address widths, memory sizes and the data word
   shared by the main-memory and video-RAM paths */

`default_nettype none

package ram_addr_pkg;

   localparam int WORD_W = 32;

   // Main memory word address as seen by the CPU
   localparam int SDRAM_AW = 22;

   // Video RAM word address
   localparam int VRAM_AW = 15;

   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [SDRAM_AW-1:0] sdram_addr_t;
   typedef logic [VRAM_AW-1:0]  vram_addr_t;

   // Implemented main memory, addresses at or above this are out of range
   localparam int MAIN_WORDS = 131072;
   localparam int MAIN_AW    = 17;

   // 21K words of video RAM
   localparam int VRAM_WORDS = 21504;

   // Out-of-range read response
   localparam word_t BAD_WORD = '1;

endpackage

`default_nettype wire

// ==== hw/ram_controller.sv ====
/* Memory controller top: main-memory sequencer and store, plus the
   dual-port video RAM for the CPU and scanout */

`default_nettype none

module ram_controller
(
   input  wire                          clk,
   input  wire                          reset,

   // Main memory
   input  wire ram_addr_pkg::sdram_addr_t sdram_addr,
   input  wire ram_addr_pkg::word_t     sdram_data_in,
   output ram_addr_pkg::word_t          sdram_data_out,
   input  wire                          sdram_req,
   output logic                         sdram_ready,
   input  wire                          sdram_write,
   output logic                         sdram_done,

   // Video RAM, CPU side
   input  wire ram_addr_pkg::vram_addr_t vram_cpu_addr,
   input  wire ram_addr_pkg::word_t     vram_cpu_data_in,
   output ram_addr_pkg::word_t          vram_cpu_data_out,
   input  wire                          vram_cpu_req,
   output logic                         vram_cpu_ready,
   input  wire                          vram_cpu_write,
   output logic                         vram_cpu_done,

   // Video RAM, scanout side
   input  wire ram_addr_pkg::vram_addr_t vram_vga_addr,
   output ram_addr_pkg::word_t          vram_vga_data_out,
   input  wire                          vram_vga_req,
   output logic                         vram_vga_ready
);
   import ram_addr_pkg::*;

   logic  timer_start;
   logic  timer_done;
   logic  mem_write_en;
   word_t mem_rdata;

   ////////////////////////////////////////////////////////////////////////////
   // Main memory path

   sdram_sequencer seq0 (
      .clk            (clk),
      .reset          (reset),
      .sdram_req      (sdram_req),
      .sdram_write    (sdram_write),
      .timer_done     (timer_done),
      .mem_rdata      (mem_rdata),
      .timer_start    (timer_start),
      .mem_write_en   (mem_write_en),
      .sdram_data_out (sdram_data_out),
      .sdram_ready    (sdram_ready),
      .sdram_done     (sdram_done)
   );

   access_timer timer0 (
      .clk   (clk),
      .reset (reset),
      .start (timer_start),
      .done  (timer_done)
   );

   main_mem_array mem0 (
      .clk      (clk),
      .addr     (sdram_addr),
      .wdata    (sdram_data_in),
      .write_en (mem_write_en),
      .rdata    (mem_rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Video RAM

   vram_dpram vram0 (
      .clk       (clk),
      .reset     (reset),
      .cpu_addr  (vram_cpu_addr),
      .cpu_wdata (vram_cpu_data_in),
      .cpu_req   (vram_cpu_req),
      .cpu_write (vram_cpu_write),
      .vga_addr  (vram_vga_addr),
      .vga_req   (vram_vga_req),
      .cpu_rdata (vram_cpu_data_out),
      .cpu_ready (vram_cpu_ready),
      .vga_rdata (vram_vga_data_out),
      .vga_ready (vram_vga_ready)
   );

   // CPU writes land on the clock edge
   assign vram_cpu_done = 1'b1;

endmodule

`default_nettype wire

// ==== hw/ram_ctrl_pkg.sv ====
/* Controller package: main-memory sequencer state encoding and access timing */

`default_nettype none

package ram_ctrl_pkg;

   // One-hot bit positions
   localparam int IDLE_BIT       = 0;
   localparam int READ_BIT       = 1;
   localparam int READ_BUSY_BIT  = 2;
   localparam int READ_WAIT_BIT  = 3;
   localparam int WRITE_BIT      = 4;
   localparam int WRITE_BUSY_BIT = 5;
   localparam int WRITE_WAIT_BIT = 6;

   typedef enum logic [6:0] {
      IDLE       = 7'b1 << IDLE_BIT,
      READ       = 7'b1 << READ_BIT,
      READ_BUSY  = 7'b1 << READ_BUSY_BIT,
      READ_WAIT  = 7'b1 << READ_WAIT_BIT,
      WRITE      = 7'b1 << WRITE_BIT,
      WRITE_BUSY = 7'b1 << WRITE_BUSY_BIT,
      WRITE_WAIT = 7'b1 << WRITE_WAIT_BIT
   } seq_state_t;

   // Back-end access time in cycles
   localparam int MEM_LATENCY = 3;
   localparam int TIMER_W     = $clog2(MEM_LATENCY + 1);

   // VRAM CPU request to ready
   localparam int CPU_READ_DELAY = 4;

endpackage

`default_nettype wire

// ==== hw/sdram_sequencer.sv ====
/* Main-memory sequencer: one-hot FSM running read and write accesses against
   the back end and producing the ready and done handshakes */

`default_nettype none

module sdram_sequencer
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        sdram_req,
   input  wire                        sdram_write,
   input  wire                        timer_done,
   input  wire ram_addr_pkg::word_t   mem_rdata,
   output logic                       timer_start,
   output logic                       mem_write_en,
   output ram_addr_pkg::word_t        sdram_data_out,
   output logic                       sdram_ready,
   output logic                       sdram_done
);
   import ram_ctrl_pkg::*;

   seq_state_t state;
   seq_state_t state_next;
   logic       capture;
   logic       int_ready;
   logic       int_done;

   ////////////////////////////////////////////////////////////////////////////
   // State machine

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= IDLE;
      else
         state <= state_next;
   end

   // Read request wins over write in idle
   always_comb
   begin
      if (state[IDLE_BIT] && sdram_req)
         state_next = READ;
      else if (state[IDLE_BIT] && sdram_write)
         state_next = WRITE;
      else if (state[READ_BIT])
         state_next = READ_BUSY;
      else if (state[READ_BUSY_BIT] && timer_done)
         state_next = READ_WAIT;
      else if (state[READ_WAIT_BIT] && !sdram_req)
         state_next = IDLE;
      else if (state[WRITE_BIT])
         state_next = WRITE_BUSY;
      else if (state[WRITE_BUSY_BIT] && timer_done)
         state_next = WRITE_WAIT;
      else if (state[WRITE_WAIT_BIT] && !sdram_write)
         state_next = IDLE;
      else
         state_next = state;
   end

   // Command issue, the timer loads as a busy state is entered
   assign timer_start  = state[READ_BIT] || state[WRITE_BIT];
   assign mem_write_en = state[WRITE_BIT];
   assign capture      = state[READ_BUSY_BIT] && timer_done;

   ////////////////////////////////////////////////////////////////////////////
   // Read data and completion flags

   always_ff @(posedge clk)
   begin
      if (reset)
         sdram_data_out <= '0;
      else if (capture)
         sdram_data_out <= mem_rdata;
   end

   // Flags come up as the wait state is entered and drop once it is left
   always_ff @(posedge clk)
   begin
      if (reset)
         int_ready <= 1'b0;
      else if (state[READ_BIT] || (state[READ_WAIT_BIT] && !sdram_req))
         int_ready <= 1'b0;
      else if (capture)
         int_ready <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         int_done <= 1'b0;
      else if (state[WRITE_BIT] || (state[WRITE_WAIT_BIT] && !sdram_write))
         int_done <= 1'b0;
      else if (state[WRITE_BUSY_BIT] && timer_done)
         int_done <= 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Requester side handshake

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sdram_ready <= 1'b0;
         sdram_done  <= 1'b0;
      end
      else
      begin
         sdram_ready <= int_ready && sdram_req;
         sdram_done  <= int_done && sdram_write;
      end
   end

endmodule

`default_nettype wire

// ==== hw/vram_dpram.sv ====
/* Video RAM: dual-port word store with a CPU read/write side and a
   read-only scanout side, each with its own ready timing */

`default_nettype none

module vram_dpram
(
   input  wire                          clk,
   input  wire                          reset,
   input  wire ram_addr_pkg::vram_addr_t cpu_addr,
   input  wire ram_addr_pkg::word_t     cpu_wdata,
   input  wire                          cpu_req,
   input  wire                          cpu_write,
   input  wire ram_addr_pkg::vram_addr_t vga_addr,
   input  wire                          vga_req,
   output ram_addr_pkg::word_t          cpu_rdata,
   output logic                         cpu_ready,
   output ram_addr_pkg::word_t          vga_rdata,
   output logic                         vga_ready
);
   import ram_addr_pkg::*;
   import ram_ctrl_pkg::*;

   word_t                     mem [VRAM_WORDS];
   word_t                     vga_q;
   word_t                     vga_hold;
   logic [CPU_READ_DELAY-1:0] cpu_ready_sr;

   initial
   begin
      for (int i = 0; i < VRAM_WORDS; i++)
         mem[i] = '0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // CPU port

   always_ff @(posedge clk)
   begin
      if (cpu_write)
         mem[cpu_addr] <= cpu_wdata;
      if (cpu_req)
         cpu_rdata <= mem[cpu_addr];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         cpu_ready_sr <= '0;
      else
         cpu_ready_sr <= {cpu_ready_sr[CPU_READ_DELAY-2:0], cpu_req};
   end

   assign cpu_ready = cpu_ready_sr[CPU_READ_DELAY-1];

   ////////////////////////////////////////////////////////////////////////////
   // Scanout port

   always_ff @(posedge clk)
   begin
      if (vga_req)
         vga_q <= mem[vga_addr];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vga_ready <= 1'b0;
         vga_hold  <= '0;
      end
      else
      begin
         vga_ready <= vga_req;
         if (vga_ready)
            vga_hold <= vga_q;
      end
   end

   // Last valid pixel word between requests
   assign vga_rdata = vga_ready ? vga_q : vga_hold;

endmodule

`default_nettype wire

// ==== sim/ram_controller_asserts.sv ====
/* Controller assertions: reset state, ready latencies and the
   main-memory request rules */

`default_nettype none

module ram_controller_asserts
(
   input wire                      clk,
   input wire                      reset,
   input wire                      sdram_req,
   input wire                      sdram_write,
   input wire                      sdram_ready,
   input wire                      sdram_done,
   input wire ram_addr_pkg::word_t sdram_data_out,
   input wire                      vram_cpu_req,
   input wire                      vram_cpu_ready,
   input wire                      vram_vga_req,
   input wire                      vram_vga_ready
);
   import ram_ctrl_pkg::*;

   // Sampling edge to registered ready, one READ cycle plus wait and output stage
   localparam int READY_DELAY = MEM_LATENCY + 3;

   reset_clears_outputs: assert property (@(posedge clk)
      $past(reset) |-> !sdram_ready && !sdram_done && !vram_cpu_ready && !vram_vga_ready
                       && sdram_data_out == '0)
      else $error("ready, done or read data not cleared by reset");

   cpu_ready_delay: assert property (@(posedge clk) disable iff (reset)
      vram_cpu_ready == $past(vram_cpu_req, CPU_READ_DELAY))
      else $error("vram_cpu_ready does not follow vram_cpu_req by the read delay");

   vga_ready_delay: assert property (@(posedge clk) disable iff (reset)
      vram_vga_ready == $past(vram_vga_req))
      else $error("vram_vga_ready does not follow vram_vga_req by one cycle");

   // Fresh request with no ready pending
   sdram_ready_latency: assert property (@(posedge clk) disable iff (reset)
      ($past(sdram_req, READY_DELAY) && !$past(sdram_req, READY_DELAY + 1)
       && !$past(sdram_ready, READY_DELAY)) |-> sdram_ready)
      else $error("sdram_ready late after a sampled request");

   req_write_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(sdram_req && sdram_write))
      else $error("sdram_req and sdram_write high together");

endmodule

bind ram_controller ram_controller_asserts asserts0 (
   .clk            (clk),
   .reset          (reset),
   .sdram_req      (sdram_req),
   .sdram_write    (sdram_write),
   .sdram_ready    (sdram_ready),
   .sdram_done     (sdram_done),
   .sdram_data_out (sdram_data_out),
   .vram_cpu_req   (vram_cpu_req),
   .vram_cpu_ready (vram_cpu_ready),
   .vram_vga_req   (vram_vga_req),
   .vram_vga_ready (vram_vga_ready)
);

`default_nettype wire

// ==== sim/ram_controller_tb.sv ====
/* Memory controller testbench: seeded random traffic on the main-memory and
   video-RAM ports, checked against an associative-array model */

`default_nettype none

module ram_controller_tb;
   import ram_addr_pkg::*;

   localparam int MAIN_OPS      = 20;
   localparam int UNTOUCHED_OPS = 8;
   localparam int BAD_OPS       = 6;
   localparam int VRAM_OPS      = 40;
   localparam int VGA_OPS       = 8;
   localparam int HOLD_CYCLES   = 12;
   localparam int HI_W          = SDRAM_AW - MAIN_AW;

   // Each port access counted once including the held read and its follow-up
   localparam int NUM_OPS = 2 * MAIN_OPS + UNTOUCHED_OPS + 4 * BAD_OPS + VRAM_OPS
                            + VGA_OPS + 2;
   localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 100;

   logic        clk = 1'b0;
   logic        reset;
   sdram_addr_t sdram_addr;
   word_t       sdram_data_in;
   word_t       sdram_data_out;
   logic        sdram_req;
   logic        sdram_ready;
   logic        sdram_write;
   logic        sdram_done;
   vram_addr_t  vram_cpu_addr;
   word_t       vram_cpu_data_in;
   word_t       vram_cpu_data_out;
   logic        vram_cpu_req;
   logic        vram_cpu_ready;
   logic        vram_cpu_write;
   logic        vram_cpu_done;
   vram_addr_t  vram_vga_addr;
   word_t       vram_vga_data_out;
   logic        vram_vga_req;
   logic        vram_vga_ready;

   int          seed = 67;
   word_t       main_model [int];
   word_t       vram_model [int];
   sdram_addr_t main_written [$];
   vram_addr_t  vram_written [$];

   ram_controller dut0 (.*);

   always #4 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and reporting

   // Out-of-range words read as all ones and unwritten words as zero
   function automatic word_t main_expected(input sdram_addr_t addr);
      int index;
      index = int'(addr[MAIN_AW-1:0]);
      if (addr[SDRAM_AW-1:MAIN_AW] != '0)
         return BAD_WORD;
      else if (main_model.exists(index))
         return main_model[index];
      else
         return '0;
   endfunction

   function automatic word_t vram_expected(input vram_addr_t addr);
      if (vram_model.exists(int'(addr)))
         return vram_model[int'(addr)];
      else
         return '0;
   endfunction

   function automatic sdram_addr_t random_main_addr();
      return sdram_addr_t'($unsigned($random(seed)) % MAIN_WORDS);
   endfunction

   function automatic vram_addr_t random_vram_addr();
      return vram_addr_t'($unsigned($random(seed)) % VRAM_WORDS);
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_sdram_word(input word_t expected, input word_t actual);
      if (actual !== expected)
         abort_run($sformatf("error sdram_data_out: expected %h, got %h", expected, actual));
   endtask

   task automatic check_vram_cpu_word(input word_t expected, input word_t actual);
      if (actual !== expected)
         abort_run($sformatf("error vram_cpu_data_out: expected %h, got %h",
                             expected, actual));
   endtask

   task automatic check_vram_vga_word(input word_t expected, input word_t actual);
      if (actual !== expected)
         abort_run($sformatf("error vram_vga_data_out: expected %h, got %h",
                             expected, actual));
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         abort_run($sformatf("error %s: expected %h, got %h", name, expected, actual));
   endtask

   task automatic check_cpu_done();
      check_flag("vram_cpu_done", 1'b1, vram_cpu_done);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Port access tasks

   task automatic sdram_write_word(input sdram_addr_t addr, input word_t data);
      @(posedge clk);
      sdram_addr    <= addr;
      sdram_data_in <= data;
      sdram_write   <= 1'b1;
      do
         @(negedge clk);
      while (!sdram_done);
      @(posedge clk);
      sdram_write <= 1'b0;
      do
         @(negedge clk);
      while (sdram_done);
      // Writes above the implemented range are dropped
      if (addr[SDRAM_AW-1:MAIN_AW] == '0)
         main_model[int'(addr[MAIN_AW-1:0])] = data;
   endtask

   task automatic sdram_read_check(input sdram_addr_t addr);
      word_t expected;
      expected = main_expected(addr);
      @(posedge clk);
      sdram_addr <= addr;
      sdram_req  <= 1'b1;
      do
         @(negedge clk);
      while (!sdram_ready);
      check_sdram_word(expected, sdram_data_out);
      @(posedge clk);
      sdram_req <= 1'b0;
      do
         @(negedge clk);
      while (sdram_ready);
   endtask

   // Held read keeps ready and its data while the address moves on
   task automatic sdram_hold_check(input sdram_addr_t addr, input sdram_addr_t next_addr);
      word_t expected;
      expected = main_expected(addr);
      @(posedge clk);
      sdram_addr <= addr;
      sdram_req  <= 1'b1;
      do
         @(negedge clk);
      while (!sdram_ready);
      @(posedge clk);
      sdram_addr <= next_addr;
      repeat (HOLD_CYCLES)
      begin
         @(negedge clk);
         check_flag("sdram_ready", 1'b1, sdram_ready);
         check_sdram_word(expected, sdram_data_out);
      end
      @(posedge clk);
      sdram_req <= 1'b0;
      do
         @(negedge clk);
      while (sdram_ready);
      sdram_read_check(next_addr);
   endtask

   task automatic vram_cpu_write_word(input vram_addr_t addr, input word_t data);
      @(posedge clk);
      vram_cpu_addr    <= addr;
      vram_cpu_data_in <= data;
      vram_cpu_write   <= 1'b1;
      @(posedge clk);
      vram_cpu_write <= 1'b0;
      vram_model[int'(addr)] = data;
      @(negedge clk);
      check_cpu_done();
   endtask

   task automatic vram_cpu_read_check(input vram_addr_t addr);
      word_t expected;
      expected = vram_expected(addr);
      @(posedge clk);
      vram_cpu_addr <= addr;
      vram_cpu_req  <= 1'b1;
      @(posedge clk);
      vram_cpu_req <= 1'b0;
      do
      begin
         @(negedge clk);
         check_cpu_done();
      end
      while (!vram_cpu_ready);
      check_vram_cpu_word(expected, vram_cpu_data_out);
   endtask

   task automatic vram_vga_read_check(input vram_addr_t addr);
      word_t expected;
      expected = vram_expected(addr);
      @(posedge clk);
      vram_vga_addr <= addr;
      vram_vga_req  <= 1'b1;
      @(posedge clk);
      vram_vga_req <= 1'b0;
      do
         @(negedge clk);
      while (!vram_vga_ready);
      check_vram_vga_word(expected, vram_vga_data_out);
      // Hold register keeps the pixel word after ready drops
      repeat (3)
      begin
         @(negedge clk);
         check_vram_vga_word(expected, vram_vga_data_out);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial
   begin
      sdram_addr_t addr;
      sdram_addr_t bad_addr;
      vram_addr_t  vaddr;

      reset            <= 1'b1;
      sdram_addr       <= '0;
      sdram_data_in    <= '0;
      sdram_req        <= 1'b0;
      sdram_write      <= 1'b0;
      vram_cpu_addr    <= '0;
      vram_cpu_data_in <= '0;
      vram_cpu_req     <= 1'b0;
      vram_cpu_write   <= 1'b0;
      vram_vga_addr    <= '0;
      vram_vga_req     <= 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);

      check_flag("sdram_ready", 1'b0, sdram_ready);
      check_flag("sdram_done", 1'b0, sdram_done);
      check_flag("vram_cpu_ready", 1'b0, vram_cpu_ready);
      check_flag("vram_vga_ready", 1'b0, vram_vga_ready);
      check_sdram_word('0, sdram_data_out);

      repeat (MAIN_OPS)
      begin
         addr = random_main_addr();
         sdram_write_word(addr, word_t'($random(seed)));
         main_written.push_back(addr);
      end
      foreach (main_written[i])
         sdram_read_check(main_written[i]);
      repeat (UNTOUCHED_OPS)
         sdram_read_check(random_main_addr());

      // Same low bits with the high bits set
      repeat (BAD_OPS)
      begin
         addr = random_main_addr();
         bad_addr = addr;
         bad_addr[SDRAM_AW-1:MAIN_AW] = HI_W'($random(seed)) | HI_W'(1);
         sdram_write_word(addr, word_t'($random(seed)));
         sdram_write_word(bad_addr, word_t'($random(seed)));
         sdram_read_check(bad_addr);
         sdram_read_check(addr);
      end

      repeat (VRAM_OPS)
      begin
         if (($random(seed) & 1) == 1 || vram_written.size() == 0)
         begin
            vaddr = random_vram_addr();
            vram_cpu_write_word(vaddr, word_t'($random(seed)));
            vram_written.push_back(vaddr);
         end
         else if (($random(seed) & 1) == 1)
            vram_cpu_read_check(random_vram_addr());
         else
            vram_cpu_read_check(vram_written[$unsigned($random(seed)) % vram_written.size()]);
      end

      repeat (VGA_OPS)
         vram_vga_read_check(vram_written[$unsigned($random(seed)) % vram_written.size()]);

      sdram_hold_check(main_written[0], main_written[1]);

      $display(">>> PASS");
      $finish;
   end

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      abort_run("timeout: the DUT never completed a handshake");
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/ram_addr_pkg.sv
hw/ram_ctrl_pkg.sv
hw/access_timer.sv
hw/main_mem_array.sv
hw/sdram_sequencer.sv
hw/vram_dpram.sv
hw/ram_controller.sv
sim/ram_controller_asserts.sv
sim/ram_controller_tb.sv
